/* bench/sys_patterns.txt */
// columns: instr pc rs1 | expected rd_we rd rd_data redirect target (all hex)
// rd and rd_data only count when rd_we is 1, target only when redirect is 1
// reset values through csrrs with rs1 = x0
300022F3 00000100 00000000 1 05 00000000 0 00000000
305022F3 00000104 00000000 1 05 00000000 0 00000000
341022F3 00000108 00000000 1 05 00000000 0 00000000
342022F3 0000010C 00000000 1 05 00000000 0 00000000
F11022F3 00000110 00000000 1 05 79737978 0 00000000
F12022F3 00000114 00000000 1 05 015FDE6D 0 00000000
7C0022F3 00000118 00000000 1 05 00000000 0 00000000
// csrrw, csrrs, csrrc on mtvec
305092F3 0000011C 00000200 1 05 00000000 0 00000000
305122F3 00000120 00000030 1 05 00000200 0 00000000
3051B2F3 00000124 00000010 1 05 00000230 0 00000000
305022F3 00000128 00000000 1 05 00000220 0 00000000
// zimm forms ignore rs1, read-only and unknown csrs keep their value
342FD2F3 0000012C DEADBEEF 1 05 00000000 0 00000000
3421F2F3 00000130 FFFFFFFF 1 05 0000001F 0 00000000
300462F3 00000134 12345678 1 05 00000000 0 00000000
342022F3 00000138 00000000 1 05 0000001C 0 00000000
300022F3 0000013C 00000000 1 05 00000008 0 00000000
F11092F3 00000140 0BADF00D 1 05 79737978 0 00000000
F11022F3 00000144 00000000 1 05 79737978 0 00000000
F12FD2F3 00000148 00000000 1 05 015FDE6D 0 00000000
F12022F3 0000014C 00000000 1 05 015FDE6D 0 00000000
7C0092F3 00000150 FFFFFFFF 1 05 00000000 0 00000000
7C0022F3 00000154 00000000 1 05 00000000 0 00000000
// ecall jumps to mtvec and fills mepc, mcause, mstatus
00000073 00000158 00000000 0 00 00000000 1 00000220
341022F3 0000015C 00000000 1 05 00000158 0 00000000
342022F3 00000160 00000000 1 05 0000000B 0 00000000
300022F3 00000164 00000000 1 05 00001800 0 00000000
// mret jumps to mepc and clears mstatus, rd = x0 gives no write
341092F3 00000168 00000400 1 05 00000158 0 00000000
30200073 0000016C 00000000 0 00 00000000 1 00000400
300022F3 00000170 00000000 1 05 00000000 0 00000000
30509073 00000174 00000300 0 00 00000000 0 00000000
30002073 00000178 00000000 0 00 00000000 0 00000000
305022F3 0000017C 00000000 1 05 00000300 0 00000000
// addi, reserved funct3, wfi: valid with no write and no redirect
00100293 00000180 00000000 0 00 00000000 0 00000000
300042F3 00000184 00000000 0 00 00000000 0 00000000
10500073 00000188 00000000 0 00 00000000 0 00000000
300022F3 0000018C 00000000 1 05 00000000 0 00000000
00000073 00000190 00000000 0 00 00000000 1 00000300
341022F3 00000194 00000000 1 05 00000190 0 00000000
300022F3 00000198 00000000 1 05 00001800 0 00000000

/* list.f */
source/sys_pkg.sv
source/sys_decode.sv
source/sys_csr_file.sv
source/sys_commit.sv
source/sys_unit_top.sv
bench/sys_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f list.f \
	--top-module sys_unit_tb \
	-o sys_unit_sim

./obj_dir/sys_unit_sim

/* bench/sys_unit_tb.sv */
module sys_unit_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_PATTERNS = 64;
	localparam int FIELDS = 8; // words per pattern line.
	localparam int LATENCY = 3;
	localparam int DRAIN_TIMEOUT = 40;
	localparam logic [31:0] END_MARK = 32'hFFFF_FFFF;

	logic clock;
	logic reset;
	logic valid_i;
	sys_pkg::instr_t instr_i;
	sys_pkg::addr_t pc_i;
	sys_pkg::data_t rs1_data_i;
	logic valid_o;
	sys_pkg::reg_idx_t rd_o;
	logic rd_we_o;
	sys_pkg::data_t rd_data_o;
	logic redirect_o;
	sys_pkg::addr_t target_o;

	logic [31:0] pattern_mem [0:MAX_PATTERNS*FIELDS-1];
	int pattern_count;
	int checked_count;
	int cycle_count = 0;
	int pending_idx[$];
	int pending_cycle[$];
	logic [7:0] lfsr_state;

	sys_unit_top sys_unit_top_inst (
		.clock(clock),
		.reset(reset),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.pc_i(pc_i),
		.rs1_data_i(rs1_data_i),
		.valid_o(valid_o),
		.rd_o(rd_o),
		.rd_we_o(rd_we_o),
		.rd_data_o(rd_data_o),
		.redirect_o(redirect_o),
		.target_o(target_o)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	// x^8 + x^6 + x^5 + x^4 + 1.
	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		logic feedback;
		feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
		return {state[6:0], feedback};
	endfunction

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic compare_field(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			report_failure($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
				test_name, expected, actual));
		end
	endtask

	task automatic load_patterns();
		for (int i = 0; i < MAX_PATTERNS * FIELDS; i++) begin
			pattern_mem[i] = END_MARK;
		end
		$readmemh("bench/sys_patterns.txt", pattern_mem);
		pattern_count = 0;
		while (pattern_count < MAX_PATTERNS && pattern_mem[pattern_count * FIELDS] !== END_MARK) begin
			pattern_count++;
		end
		assert (pattern_count > 0) else begin
			report_failure("no patterns were read from bench/sys_patterns.txt");
		end
	endtask

	task automatic drive_pattern(input int idx);
		int base;
		base = idx * FIELDS;
		valid_i = 1'b1;
		instr_i = pattern_mem[base];
		pc_i = pattern_mem[base + 1];
		rs1_data_i = pattern_mem[base + 2];
		pending_idx.push_back(idx);
		pending_cycle.push_back(cycle_count); // edge just before the sampling edge.
	endtask

	// an ecall word without valid must leave the csrs alone.
	task automatic drive_idle();
		valid_i = 1'b0;
		instr_i = 32'h0000_0073;
		pc_i = '0;
		rs1_data_i = '1;
	endtask

	task automatic check_output();
		int idx;
		int issue_cycle;
		int base;
		string name;
		assert (pending_idx.size() > 0) else begin
			report_failure("valid_o went high with no instruction in flight");
		end
		idx = pending_idx.pop_front();
		issue_cycle = pending_cycle.pop_front();
		base = idx * FIELDS;
		name = $sformatf("pattern_%0d", idx);
		assert (cycle_count == issue_cycle + LATENCY) else begin
			report_failure($sformatf("%s came out after %0d cycles instead of %0d",
				name, cycle_count - issue_cycle, LATENCY));
		end
		compare_field({name, ".rd_we"}, pattern_mem[base + 3], 32'(rd_we_o));
		compare_field({name, ".redirect"}, pattern_mem[base + 6], 32'(redirect_o));
		if (pattern_mem[base + 3][0]) begin
			compare_field({name, ".rd"}, pattern_mem[base + 4], 32'(rd_o));
			compare_field({name, ".rd_data"}, pattern_mem[base + 5], rd_data_o);
		end
		if (pattern_mem[base + 6][0]) begin
			compare_field({name, ".target"}, pattern_mem[base + 7], target_o);
		end
		checked_count++;
	endtask

	// outputs settle well before the falling edge.
	initial begin
		forever begin
			@(negedge clock);
			if (reset === 1'b0) begin
				assert (!$isunknown(valid_o)) else begin
					report_failure("valid_o is unknown after reset");
				end
				if (valid_o) begin
					check_output();
				end
			end
		end
	end

	initial begin
		int idx;
		int wait_count;
		reset = 1'b1;
		valid_i = 1'b0;
		instr_i = '0;
		pc_i = '0;
		rs1_data_i = '0;
		checked_count = 0;
		lfsr_state = 8'd20;
		load_patterns();
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;
		idx = 0;
		while (idx < pattern_count) begin
			lfsr_state = lfsr_next(lfsr_state);
			if (lfsr_state[0]) begin
				drive_idle(); // random gap.
			end else begin
				drive_pattern(idx);
				idx++;
			end
			@(posedge clock);
			#2;
		end
		drive_idle();
		wait_count = 0;
		while (checked_count < pattern_count && wait_count < DRAIN_TIMEOUT) begin
			@(posedge clock);
			wait_count++;
		end
		if (checked_count < pattern_count) begin
			report_failure("timeout waiting for outputs");
		end else begin
			repeat (LATENCY + 1) @(posedge clock); // catches a stray valid_o.
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* source/sys_unit_top.sv */
module sys_unit_top (
	input logic clock,
	input logic reset,

	input logic valid_i,
	input sys_pkg::instr_t instr_i,
	input sys_pkg::addr_t pc_i,
	input sys_pkg::data_t rs1_data_i,

	output logic valid_o,
	output sys_pkg::reg_idx_t rd_o,
	output logic rd_we_o,
	output sys_pkg::data_t rd_data_o,
	output logic redirect_o,
	output sys_pkg::addr_t target_o
);

	// decode to csr stage.
	logic d_valid;
	sys_pkg::sys_kind_t d_kind;
	sys_pkg::csr_addr_t d_csr_addr;
	sys_pkg::data_t d_operand;
	sys_pkg::reg_idx_t d_rd;
	sys_pkg::addr_t d_pc;

	// csr stage to commit.
	logic c_valid;
	sys_pkg::reg_idx_t c_rd;
	logic c_rd_we;
	sys_pkg::data_t c_rd_data;
	logic c_redirect;
	sys_pkg::addr_t c_target;

	sys_decode sys_decode_inst (
		.clock(clock),
		.reset(reset),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.pc_i(pc_i),
		.rs1_data_i(rs1_data_i),
		.valid_o(d_valid),
		.kind_o(d_kind),
		.csr_addr_o(d_csr_addr),
		.operand_o(d_operand),
		.rd_o(d_rd),
		.pc_o(d_pc)
	);

	sys_csr_file sys_csr_file_inst (
		.clock(clock),
		.reset(reset),
		.valid_i(d_valid),
		.kind_i(d_kind),
		.csr_addr_i(d_csr_addr),
		.operand_i(d_operand),
		.rd_i(d_rd),
		.pc_i(d_pc),
		.valid_o(c_valid),
		.rd_o(c_rd),
		.rd_we_o(c_rd_we),
		.rd_data_o(c_rd_data),
		.redirect_o(c_redirect),
		.target_o(c_target)
	);

	sys_commit sys_commit_inst (
		.clock(clock),
		.reset(reset),
		.valid_i(c_valid),
		.rd_i(c_rd),
		.rd_we_i(c_rd_we),
		.rd_data_i(c_rd_data),
		.redirect_i(c_redirect),
		.target_i(c_target),
		.valid_o(valid_o),
		.rd_o(rd_o),
		.rd_we_o(rd_we_o),
		.rd_data_o(rd_data_o),
		.redirect_o(redirect_o),
		.target_o(target_o)
	);

endmodule

/* source/sys_commit.sv */
module sys_commit (
	input logic clock,
	input logic reset,

	input logic valid_i,
	input sys_pkg::reg_idx_t rd_i,
	input logic rd_we_i,
	input sys_pkg::data_t rd_data_i,
	input logic redirect_i,
	input sys_pkg::addr_t target_i,

	output logic valid_o,
	output sys_pkg::reg_idx_t rd_o,
	output logic rd_we_o,
	output sys_pkg::data_t rd_data_o,
	output logic redirect_o,
	output sys_pkg::addr_t target_o
);

	logic rd_we_gated;
	logic redirect_gated;

	// strobes only count while the slot is valid.
	assign rd_we_gated = valid_i && rd_we_i;
	assign redirect_gated = valid_i && redirect_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_o <= 1'b0;
			rd_we_o <= 1'b0;
			redirect_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			rd_we_o <= rd_we_gated;
			redirect_o <= redirect_gated;
		end
	end

	always_ff @(posedge clock) begin
		rd_o <= rd_i;
		rd_data_o <= rd_data_i;
		target_o <= target_i;
	end

endmodule

/* source/sys_csr_file.sv */
module sys_csr_file (
	input logic clock,
	input logic reset,

	input logic valid_i,
	input sys_pkg::sys_kind_t kind_i,
	input sys_pkg::csr_addr_t csr_addr_i,
	input sys_pkg::data_t operand_i,
	input sys_pkg::reg_idx_t rd_i,
	input sys_pkg::addr_t pc_i,

	output logic valid_o,
	output sys_pkg::reg_idx_t rd_o,
	output logic rd_we_o,
	output sys_pkg::data_t rd_data_o,
	output logic redirect_o,
	output sys_pkg::addr_t target_o
);

	sys_pkg::data_t mstatus_q;
	sys_pkg::data_t mtvec_q;
	sys_pkg::data_t mepc_q;
	sys_pkg::data_t mcause_q;

	sys_pkg::data_t old_value;
	sys_pkg::data_t new_value;
	logic is_csr;
	logic is_ecall;
	logic is_mret;
	logic csr_write;

	assign is_csr = (kind_i == sys_pkg::kind_csrrw) || (kind_i == sys_pkg::kind_csrrs)
		|| (kind_i == sys_pkg::kind_csrrc);
	assign is_ecall = (kind_i == sys_pkg::kind_ecall);
	assign is_mret = (kind_i == sys_pkg::kind_mret);
	assign csr_write = valid_i && is_csr;

	// read port, unknown addresses read zero.
	always_comb begin
		case (csr_addr_i)
			sys_pkg::MSTATUS_ADDR: old_value = mstatus_q;
			sys_pkg::MTVEC_ADDR: old_value = mtvec_q;
			sys_pkg::MEPC_ADDR: old_value = mepc_q;
			sys_pkg::MCAUSE_ADDR: old_value = mcause_q;
			sys_pkg::MVENDORID_ADDR: old_value = sys_pkg::MVENDORID_VALUE;
			sys_pkg::MARCHID_ADDR: old_value = sys_pkg::MARCHID_VALUE;
			default: old_value = '0;
		endcase
	end

	always_comb begin
		case (kind_i)
			sys_pkg::kind_csrrw: new_value = operand_i;
			sys_pkg::kind_csrrs: new_value = old_value | operand_i;
			sys_pkg::kind_csrrc: new_value = old_value & ~operand_i;
			default: new_value = old_value;
		endcase
	end

	// trap effects take priority over the csr write port.
	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus_q <= '0;
			mtvec_q <= '0;
			mepc_q <= '0;
			mcause_q <= '0;
		end else if (valid_i) begin
			if (is_ecall) begin
				mstatus_q <= sys_pkg::ECALL_MSTATUS;
				mepc_q <= pc_i;
				mcause_q <= sys_pkg::ECALL_CAUSE;
			end else if (is_mret) begin
				mstatus_q <= '0;
			end else if (csr_write) begin
				case (csr_addr_i)
					sys_pkg::MSTATUS_ADDR: mstatus_q <= new_value;
					sys_pkg::MTVEC_ADDR: mtvec_q <= new_value;
					sys_pkg::MEPC_ADDR: mepc_q <= new_value;
					sys_pkg::MCAUSE_ADDR: mcause_q <= new_value;
					default: ; // read-only or absent.
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_o <= 1'b0;
			rd_we_o <= 1'b0;
			redirect_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			rd_we_o <= csr_write && (rd_i != '0);
			redirect_o <= valid_i && (is_ecall || is_mret);
		end
	end

	always_ff @(posedge clock) begin
		rd_o <= rd_i;
		rd_data_o <= old_value;
		target_o <= is_ecall ? mtvec_q : mepc_q; // mepc before this edge.
	end

	// a csr read right behind an ecall already sees its pc in mepc.
	assert property (@(posedge clock) disable iff (reset)
		(valid_i && is_ecall)
		##1 (valid_i && is_csr && (csr_addr_i == sys_pkg::MEPC_ADDR))
		|=> (rd_data_o == $past(pc_i, 2)));

	// an mret right behind an ecall returns to the ecall itself.
	assert property (@(posedge clock) disable iff (reset)
		(valid_i && is_ecall) ##1 (valid_i && is_mret)
		|=> (target_o == $past(pc_i, 2)));

endmodule

/* source/sys_decode.sv */
module sys_decode (
	input logic clock,
	input logic reset,

	input logic valid_i,
	input sys_pkg::instr_t instr_i,
	input sys_pkg::addr_t pc_i,
	input sys_pkg::data_t rs1_data_i,

	output logic valid_o,
	output sys_pkg::sys_kind_t kind_o,
	output sys_pkg::csr_addr_t csr_addr_o,
	output sys_pkg::data_t operand_o,
	output sys_pkg::reg_idx_t rd_o,
	output sys_pkg::addr_t pc_o
);

	sys_pkg::opcode_t opcode;
	logic [2:0] funct3;
	sys_pkg::csr_addr_t funct12;
	sys_pkg::reg_idx_t rd_field;
	sys_pkg::reg_idx_t rs1_field;

	sys_pkg::sys_kind_t kind_next;
	sys_pkg::data_t operand_next;

	assign opcode = instr_i[6:0];
	assign rd_field = instr_i[11:7];
	assign funct3 = instr_i[14:12];
	assign rs1_field = instr_i[19:15];
	assign funct12 = instr_i[31:20]; // also the csr address.

	always_comb begin
		kind_next = sys_pkg::kind_none;
		if (opcode == sys_pkg::SYSTEM_OPCODE) begin
			case (funct3[1:0])
				sys_pkg::FUNCT3_CSRRW[1:0]: kind_next = sys_pkg::kind_csrrw;
				sys_pkg::FUNCT3_CSRRS[1:0]: kind_next = sys_pkg::kind_csrrs;
				sys_pkg::FUNCT3_CSRRC[1:0]: kind_next = sys_pkg::kind_csrrc;
				default: begin
					// 000 is ecall or mret, 100 is reserved.
					if (funct3 == sys_pkg::FUNCT3_PRIV) begin
						if (funct12 == sys_pkg::ECALL_FUNCT12) begin
							kind_next = sys_pkg::kind_ecall;
						end else if (funct12 == sys_pkg::MRET_FUNCT12) begin
							kind_next = sys_pkg::kind_mret;
						end
					end
				end
			endcase
		end
	end

	// immediate forms take zimm zero extended.
	always_comb begin
		if (funct3[2]) begin
			operand_next = sys_pkg::data_t'(rs1_field);
		end else begin
			operand_next = rs1_data_i;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clock) begin
		kind_o <= kind_next;
		csr_addr_o <= funct12;
		operand_o <= operand_next;
		rd_o <= rd_field;
		pc_o <= pc_i;
	end

endmodule

/* source/sys_pkg.sv */
package sys_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	localparam int INSTR_WIDTH = 32;
	localparam int CSR_ADDR_WIDTH = 12;
	localparam int REG_IDX_WIDTH = 5;
	localparam int OPCODE_WIDTH = 7;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [INSTR_WIDTH-1:0] instr_t;
	typedef logic [CSR_ADDR_WIDTH-1:0] csr_addr_t;
	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [OPCODE_WIDTH-1:0] opcode_t;

	// what stage 2 has to do with the instruction
	typedef enum logic [2:0] {
		kind_none,
		kind_csrrw,
		kind_csrrs,
		kind_csrrc,
		kind_ecall,
		kind_mret
	} sys_kind_t;

	localparam opcode_t SYSTEM_OPCODE = 7'h73;

	// funct12 values that tell the two privileged forms apart.
	localparam csr_addr_t ECALL_FUNCT12 = 12'h000;
	localparam csr_addr_t MRET_FUNCT12 = 12'h302;

	// funct3 values, bit 2 marks the zimm forms.
	localparam logic [2:0] FUNCT3_PRIV = 3'b000;
	localparam logic [2:0] FUNCT3_CSRRW = 3'b001;
	localparam logic [2:0] FUNCT3_CSRRS = 3'b010;
	localparam logic [2:0] FUNCT3_CSRRC = 3'b011;

	// machine-mode CSR addresses.
	localparam csr_addr_t MSTATUS_ADDR = 12'h300;
	localparam csr_addr_t MTVEC_ADDR = 12'h305;
	localparam csr_addr_t MEPC_ADDR = 12'h341;
	localparam csr_addr_t MCAUSE_ADDR = 12'h342;
	localparam csr_addr_t MVENDORID_ADDR = 12'hF11;
	localparam csr_addr_t MARCHID_ADDR = 12'hF12;

	// read-only identification values.
	localparam data_t MVENDORID_VALUE = 32'h7973_7978;
	localparam data_t MARCHID_VALUE = 32'h015F_DE6D;

	// trap side effects of ECALL.
	localparam data_t ECALL_MSTATUS = 32'h0000_1800; // mpp = machine.
	localparam data_t ECALL_CAUSE = 32'd11; // environment call from m-mode.

endpackage
